// ==== tests/cache_patterns.txt ====
// Fields in order: LFSR seed, request count, 256 backing-store words for
// offsets 0x00 to 0xff from address 0xa00, expected hit count, expected miss count
// Seed
88d65ffa
// Requests
00000014
// Backing store, eight words per line
f5ff0a00 f5fe0a01 f5fd0a02 f5fc0a03 f5fb0a04 f5fa0a05 f5f90a06 f5f80a07
f5f70a08 f5f60a09 f5f50a0a f5f40a0b f5f30a0c f5f20a0d f5f10a0e f5f00a0f
f5ef0a10 f5ee0a11 f5ed0a12 f5ec0a13 f5eb0a14 f5ea0a15 f5e90a16 f5e80a17
f5e70a18 f5e60a19 f5e50a1a f5e40a1b f5e30a1c f5e20a1d f5e10a1e f5e00a1f
f5df0a20 f5de0a21 f5dd0a22 f5dc0a23 f5db0a24 f5da0a25 f5d90a26 f5d80a27
f5d70a28 f5d60a29 f5d50a2a f5d40a2b f5d30a2c f5d20a2d f5d10a2e f5d00a2f
f5cf0a30 f5ce0a31 f5cd0a32 f5cc0a33 f5cb0a34 f5ca0a35 f5c90a36 f5c80a37
f5c70a38 f5c60a39 f5c50a3a f5c40a3b f5c30a3c f5c20a3d f5c10a3e f5c00a3f
f5bf0a40 f5be0a41 f5bd0a42 f5bc0a43 f5bb0a44 f5ba0a45 f5b90a46 f5b80a47
f5b70a48 f5b60a49 f5b50a4a f5b40a4b f5b30a4c f5b20a4d f5b10a4e f5b00a4f
f5af0a50 f5ae0a51 f5ad0a52 f5ac0a53 f5ab0a54 f5aa0a55 f5a90a56 f5a80a57
f5a70a58 f5a60a59 f5a50a5a f5a40a5b f5a30a5c f5a20a5d f5a10a5e f5a00a5f
f59f0a60 f59e0a61 f59d0a62 f59c0a63 f59b0a64 f59a0a65 f5990a66 f5980a67
f5970a68 f5960a69 f5950a6a f5940a6b f5930a6c f5920a6d f5910a6e f5900a6f
f58f0a70 f58e0a71 f58d0a72 f58c0a73 f58b0a74 f58a0a75 f5890a76 f5880a77
f5870a78 f5860a79 f5850a7a f5840a7b f5830a7c f5820a7d f5810a7e f5800a7f
f57f0a80 f57e0a81 f57d0a82 f57c0a83 f57b0a84 f57a0a85 f5790a86 f5780a87
f5770a88 f5760a89 f5750a8a f5740a8b f5730a8c f5720a8d f5710a8e f5700a8f
f56f0a90 f56e0a91 f56d0a92 f56c0a93 f56b0a94 f56a0a95 f5690a96 f5680a97
f5670a98 f5660a99 f5650a9a f5640a9b f5630a9c f5620a9d f5610a9e f5600a9f
f55f0aa0 f55e0aa1 f55d0aa2 f55c0aa3 f55b0aa4 f55a0aa5 f5590aa6 f5580aa7
f5570aa8 f5560aa9 f5550aaa f5540aab f5530aac f5520aad f5510aae f5500aaf
f54f0ab0 f54e0ab1 f54d0ab2 f54c0ab3 f54b0ab4 f54a0ab5 f5490ab6 f5480ab7
f5470ab8 f5460ab9 f5450aba f5440abb f5430abc f5420abd f5410abe f5400abf
f53f0ac0 f53e0ac1 f53d0ac2 f53c0ac3 f53b0ac4 f53a0ac5 f5390ac6 f5380ac7
f5370ac8 f5360ac9 f5350aca f5340acb f5330acc f5320acd f5310ace f5300acf
f52f0ad0 f52e0ad1 f52d0ad2 f52c0ad3 f52b0ad4 f52a0ad5 f5290ad6 f5280ad7
f5270ad8 f5260ad9 f5250ada f5240adb f5230adc f5220add f5210ade f5200adf
f51f0ae0 f51e0ae1 f51d0ae2 f51c0ae3 f51b0ae4 f51a0ae5 f5190ae6 f5180ae7
f5170ae8 f5160ae9 f5150aea f5140aeb f5130aec f5120aed f5110aee f5100aef
f50f0af0 f50e0af1 f50d0af2 f50c0af3 f50b0af4 f50a0af5 f5090af6 f5080af7
f5070af8 f5060af9 f5050afa f5040afb f5030afc f5020afd f5010afe f5000aff
// Expected hits, then misses
00000009
0000000b

// ==== project.f ====
+incdir+include
rtl/cache_pkg.sv
rtl/sync_ram.sv
rtl/cpu_req_gen.sv
rtl/tag_lookup.sv
rtl/line_fill.sv
rtl/resp_stage.sv
rtl/cache_top.sv
tests/tb_cache_top.sv

// ==== Makefile ====
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= tb_cache_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
FAIL_MSG  ?= TESTBENCH FAILED
PASS_MSG  ?= TESTBENCH PASSED

SOURCES := $(wildcard rtl/*.sv include/*.svh tests/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_cache_top.sv ====
`include "cache_config.svh"

module tb_cache_top
    import cache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // x^32 + x^22 + x^2 + x + 1, Galois form shifting right
    localparam word_t LFSR_POLY = 32'h8020_0003;
    localparam int LINES = 2 ** `CACHE_LINES_LOG2;
    localparam int PAT_WORDS = 260;

    logic       cpu_intf = 1'b0;
    logic       rst_n;
    logic       run;
    word_t      seed;
    logic       load_en;
    mem_index_t load_index;
    word_t      load_data;
    logic       req_valid;
    addr_t      req_addr;
    logic       resp_valid;
    addr_t      resp_addr;
    word_t      resp_data;
    logic       resp_hit;
    count_t     hit_count;
    count_t     miss_count;

    logic [31:0] pattern_words [PAT_WORDS];
    word_t       mem_words [256];
    int          n_req = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycle = 0;
    int          req_count = 0;
    int          resp_count = 0;
    int          last_req_cycle = 0;

    // Reference model of the generator and the cache
    word_t      model_lfsr;
    mem_index_t hist_ring [`HIST_DEPTH];
    int         hist_wr = 0;
    int         hist_fill = 0;
    logic       sb_valid [LINES];
    tag_t       sb_tag [LINES];
    int         model_hits = 0;
    int         model_misses = 0;
    int         reuse_seen = 0;
    int         evictions = 0;

    // Outstanding requests, oldest first
    addr_t exp_addr_q [$];
    logic  exp_hit_q [$];
    int    due_q [$];

    cache_top u_cache_top (
        .cpu_intf   (cpu_intf),
        .rst_n      (rst_n),
        .run        (run),
        .seed       (seed),
        .load_en    (load_en),
        .load_index (load_index),
        .load_data  (load_data),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .resp_valid (resp_valid),
        .resp_addr  (resp_addr),
        .resp_data  (resp_data),
        .resp_hit   (resp_hit),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    always #2 cpu_intf = ~cpu_intf;

    task automatic check_word(input string name, input word_t exp, input word_t got);
        checks++;
        if (got !== exp) begin
            $display("Fail %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t got);
        checks++;
        if (got !== exp) begin
            $display("Fail %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t got);
        checks++;
        if (got !== exp) begin
            $display("Fail %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_hit(input string name, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            $display("Fail %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    function automatic word_t lfsr_advance(input word_t s);
        return (s >> 1) ^ (s[0] ? LFSR_POLY : 32'h0);
    endfunction

    // Next address from the reuse history rule
    task automatic predict_request(output addr_t addr);
        mem_index_t off;
        int         pick;
        if (model_lfsr[8] && hist_fill != 0) begin
            pick = int'(model_lfsr[11:9]) % hist_fill;
            off = hist_ring[pick];
            reuse_seen++;
        end else begin
            off = model_lfsr[7:0];
            hist_ring[hist_wr] = off;
            hist_wr = (hist_wr + 1) % `HIST_DEPTH;
            if (hist_fill < `HIST_DEPTH) begin
                hist_fill++;
            end
        end
        model_lfsr = lfsr_advance(model_lfsr);
        addr = `ADDR_BASE + addr_t'(off);
    endtask

    task automatic lookup_scoreboard(input addr_t addr, output logic hit);
        index_t idx;
        tag_t   tag;
        idx = addr[`CACHE_LINES_LOG2-1:0];
        tag = addr[31:`CACHE_LINES_LOG2];
        hit = sb_valid[idx] && (sb_tag[idx] == tag);
        if (hit) begin
            model_hits++;
        end else begin
            // Alias with another tag gets evicted
            if (sb_valid[idx]) begin
                evictions++;
            end
            sb_valid[idx] = 1'b1;
            sb_tag[idx] = tag;
            model_misses++;
        end
    endtask

    always @(negedge cpu_intf) begin : monitor
        addr_t      exp_addr;
        logic       exp_hit;
        int         due;
        mem_index_t off;
        cycle = cycle + 1;
        if (rst_n && !run && (req_valid || resp_valid)) begin
            $display("A request or response strobe was seen while run was low");
            errors++;
        end
        if (req_valid) begin
            req_count++;
            // One strobe per request period
            if (req_count > 1 && cycle - last_req_cycle != `REQ_PERIOD) begin
                $display("Request %0d came %0d cycles after the previous one instead of %0d",
                         req_count, cycle - last_req_cycle, `REQ_PERIOD);
                errors++;
            end
            last_req_cycle = cycle;
            if (req_count > n_req) begin
                $display("Request %0d was issued beyond the %0d expected", req_count, n_req);
                errors++;
            end else begin
                predict_request(exp_addr);
                check_addr("req_addr", exp_addr, req_addr);
                if (req_addr - `ADDR_BASE > 32'd255) begin
                    $display("Request address %h lies outside the 256-word window", req_addr);
                    errors++;
                end
                lookup_scoreboard(exp_addr, exp_hit);
                due = cycle + (exp_hit ? 3 : `FILL_WAIT + 3);
                exp_addr_q.push_back(exp_addr);
                exp_hit_q.push_back(exp_hit);
                due_q.push_back(due);
            end
        end
        if (resp_valid) begin
            if (exp_addr_q.size() == 0) begin
                $display("A response arrived with no request outstanding");
                errors++;
            end else begin
                exp_addr = exp_addr_q.pop_front();
                exp_hit = exp_hit_q.pop_front();
                due = due_q.pop_front();
                if (cycle != due) begin
                    $display("Response for %h arrived at cycle %0d instead of cycle %0d",
                             exp_addr, cycle, due);
                    errors++;
                end
                off = mem_index_t'(exp_addr - `ADDR_BASE);
                check_addr("resp_addr", exp_addr, resp_addr);
                check_word("resp_data", mem_words[off], resp_data);
                check_hit("resp_hit", exp_hit, resp_hit);
                resp_count++;
            end
        end
    end

    initial begin
        int i;
        int limit;
        int run_cycles;
        rst_n = 1'b0;
        run = 1'b0;
        seed = '0;
        load_en = 1'b0;
        load_index = '0;
        load_data = '0;
        for (i = 0; i < LINES; i++) begin
            sb_valid[i] = 1'b0;
            sb_tag[i] = '0;
        end
        $readmemh("tests/cache_patterns.txt", pattern_words);
        if ($isunknown(pattern_words[1]) || pattern_words[1] == 32'h0) begin
            $display("Pattern file tests/cache_patterns.txt is missing or has no requests");
            errors++;
        end else begin
            n_req = int'(pattern_words[1]);
            seed = pattern_words[0];
        end
        model_lfsr = seed;

        repeat (3) @(negedge cpu_intf);
        rst_n <= 1'b1;

        // Backing store preload, one word per cycle
        for (i = 0; i < 256; i++) begin
            @(negedge cpu_intf);
            load_en <= 1'b1;
            load_index <= mem_index_t'(i);
            load_data <= pattern_words[2 + i];
            mem_words[i] = pattern_words[2 + i];
        end
        @(negedge cpu_intf);
        load_en <= 1'b0;
        repeat (4) @(negedge cpu_intf);
        run <= 1'b1;

        limit = n_req * `REQ_PERIOD + 50;
        run_cycles = 0;
        while (resp_count < n_req && run_cycles < limit) begin
            @(posedge cpu_intf);
            run_cycles++;
        end
        @(negedge cpu_intf);
        run <= 1'b0;
        if (resp_count < n_req) begin
            $display("Timeout after %0d cycles with %0d of %0d responses",
                     run_cycles, resp_count, n_req);
            errors++;
        end

        check_count("hit_count", count_t'(model_hits), hit_count);
        check_count("miss_count", count_t'(model_misses), miss_count);
        check_count("hit_count", count_t'(pattern_words[PAT_WORDS-2]), hit_count);
        check_count("miss_count", count_t'(pattern_words[PAT_WORDS-1]), miss_count);
        if (int'(hit_count) + int'(miss_count) != n_req) begin
            $display("Hit and miss counts do not add up to %0d requests", n_req);
            errors++;
        end
        if (reuse_seen == 0 || evictions == 0) begin
            $display("Stimulus produced no reused address or no alias eviction");
            errors++;
        end

        @(posedge cpu_intf);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/cache_top.sv ====
module cache_top
    import cache_pkg::*;
(
    input  logic       cpu_intf,
    input  logic       rst_n,
    input  logic       run,
    input  word_t      seed,
    input  logic       load_en,
    input  mem_index_t load_index,
    input  word_t      load_data,
    output logic       req_valid,
    output addr_t      req_addr,
    output logic       resp_valid,
    output addr_t      resp_addr,
    output word_t      resp_data,
    output logic       resp_hit,
    output count_t     hit_count,
    output count_t     miss_count
);

    logic       look_valid;
    addr_t      look_addr;
    logic       look_hit;
    logic       tag_wr_en;
    index_t     tag_wr_index;
    tag_entry_t tag_wr_entry;
    logic       done_valid;
    addr_t      done_addr;
    word_t      done_data;
    logic       done_hit;
    mem_index_t mem_rd_index;
    word_t      mem_rd_data;

    cpu_req_gen u_cpu_req_gen (
        .cpu_intf  (cpu_intf),
        .rst_n     (rst_n),
        .run       (run),
        .seed      (seed),
        .req_valid (req_valid),
        .req_addr  (req_addr)
    );

    tag_lookup u_tag_lookup (
        .cpu_intf     (cpu_intf),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .tag_wr_en    (tag_wr_en),
        .tag_wr_index (tag_wr_index),
        .tag_wr_entry (tag_wr_entry),
        .look_valid   (look_valid),
        .look_addr    (look_addr),
        .look_hit     (look_hit)
    );

    line_fill u_line_fill (
        .cpu_intf     (cpu_intf),
        .rst_n        (rst_n),
        .look_valid   (look_valid),
        .look_addr    (look_addr),
        .look_hit     (look_hit),
        .tag_wr_en    (tag_wr_en),
        .tag_wr_index (tag_wr_index),
        .tag_wr_entry (tag_wr_entry),
        .done_valid   (done_valid),
        .done_addr    (done_addr),
        .done_data    (done_data),
        .done_hit     (done_hit),
        .mem_rd_index (mem_rd_index),
        .mem_rd_data  (mem_rd_data)
    );

    resp_stage u_resp_stage (
        .cpu_intf   (cpu_intf),
        .rst_n      (rst_n),
        .done_valid (done_valid),
        .done_addr  (done_addr),
        .done_data  (done_data),
        .done_hit   (done_hit),
        .resp_valid (resp_valid),
        .resp_addr  (resp_addr),
        .resp_data  (resp_data),
        .resp_hit   (resp_hit),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    // Backing store, written only through the load port
    sync_ram #(
        .entry_t    (word_t),
        .DEPTH_LOG2 ($bits(mem_index_t))
    ) u_backing_ram (
        .cpu_intf (cpu_intf),
        .wr_en    (load_en),
        .wr_index (load_index),
        .wr_data  (load_data),
        .rd_index (mem_rd_index),
        .rd_data  (mem_rd_data)
    );

endmodule

// ==== rtl/resp_stage.sv ====
module resp_stage
    import cache_pkg::*;
(
    input  logic   cpu_intf,
    input  logic   rst_n,
    input  logic   done_valid,
    input  addr_t  done_addr,
    input  word_t  done_data,
    input  logic   done_hit,
    output logic   resp_valid,
    output addr_t  resp_addr,
    output word_t  resp_data,
    output logic   resp_hit,
    output count_t hit_count,
    output count_t miss_count
);

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            resp_valid <= done_valid;
            if (done_valid) begin
                // Counters stick at their maximum
                if (done_hit) begin
                    if (hit_count != '1) begin
                        hit_count <= hit_count + 1'b1;
                    end
                end else begin
                    if (miss_count != '1) begin
                        miss_count <= miss_count + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (done_valid) begin
            resp_addr <= done_addr;
            resp_data <= done_data;
            resp_hit  <= done_hit;
        end
    end

endmodule

// ==== rtl/line_fill.sv ====
`include "cache_config.svh"

module line_fill
    import cache_pkg::*;
(
    input  logic       cpu_intf,
    input  logic       rst_n,
    input  logic       look_valid,
    input  addr_t      look_addr,
    input  logic       look_hit,
    output logic       tag_wr_en,
    output index_t     tag_wr_index,
    output tag_entry_t tag_wr_entry,
    output logic       done_valid,
    output addr_t      done_addr,
    output word_t      done_data,
    output logic       done_hit,
    output mem_index_t mem_rd_index,
    input  word_t      mem_rd_data
);

    typedef enum logic {
        ST_IDLE,
        ST_FILL
    } state_t;

    localparam int WAIT_W = $clog2(`FILL_WAIT + 1);

    state_t            state;
    logic [WAIT_W-1:0] wait_cnt;
    logic              fill_done;
    addr_t             cur_addr;
    addr_t             mem_offset;
    index_t            look_index;
    word_t             data_rd_data;

    assign look_index = look_addr[`CACHE_LINES_LOG2-1:0];
    assign fill_done = (state == ST_FILL) && (wait_cnt == WAIT_W'(`FILL_WAIT - 1));

    // Backing store index stays put for the whole fill
    assign mem_offset = cur_addr - `ADDR_BASE;
    assign mem_rd_index = mem_offset[$bits(mem_index_t)-1:0];

    assign done_addr = cur_addr;
    assign done_data = done_hit ? data_rd_data : mem_rd_data;

    // Refill of tag and data lands in the done cycle of a miss
    assign tag_wr_en = done_valid && !done_hit;
    assign tag_wr_index = cur_addr[`CACHE_LINES_LOG2-1:0];
    assign tag_wr_entry.valid = 1'b1;
    assign tag_wr_entry.tag = cur_addr[31:`CACHE_LINES_LOG2];

    sync_ram #(
        .entry_t    (word_t),
        .DEPTH_LOG2 (`CACHE_LINES_LOG2)
    ) u_data_ram (
        .cpu_intf (cpu_intf),
        .wr_en    (tag_wr_en),
        .wr_index (tag_wr_index),
        .wr_data  (mem_rd_data),
        .rd_index (look_index),
        .rd_data  (data_rd_data)
    );

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            wait_cnt   <= '0;
            done_valid <= 1'b0;
        end else begin
            done_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    wait_cnt <= '0;
                    if (look_valid) begin
                        if (look_hit) begin
                            done_valid <= 1'b1;
                        end else begin
                            state <= ST_FILL;
                        end
                    end
                end
                ST_FILL: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (fill_done) begin
                        done_valid <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (look_valid) begin
            cur_addr <= look_addr;
            done_hit <= look_hit;
        end
    end

endmodule

// ==== rtl/tag_lookup.sv ====
`include "cache_config.svh"

module tag_lookup
    import cache_pkg::*;
(
    input  logic       cpu_intf,
    input  logic       rst_n,
    input  logic       req_valid,
    input  addr_t      req_addr,
    input  logic       tag_wr_en,
    input  index_t     tag_wr_index,
    input  tag_entry_t tag_wr_entry,
    output logic       look_valid,
    output addr_t      look_addr,
    output logic       look_hit
);

    localparam int LINES = 2 ** `CACHE_LINES_LOG2;

    index_t           req_index;
    tag_t             look_tag;
    tag_entry_t       rd_entry;
    logic [LINES-1:0] valid_bits;
    logic             valid_q;

    assign req_index = req_addr[`CACHE_LINES_LOG2-1:0];
    assign look_tag = look_addr[31:`CACHE_LINES_LOG2];

    sync_ram #(
        .entry_t    (tag_entry_t),
        .DEPTH_LOG2 (`CACHE_LINES_LOG2)
    ) u_tag_ram (
        .cpu_intf (cpu_intf),
        .wr_en    (tag_wr_en),
        .wr_index (tag_wr_index),
        .wr_data  (tag_wr_entry),
        .rd_index (req_index),
        .rd_data  (rd_entry)
    );

    // Valid bits live in flops so every line reads as invalid after reset
    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            valid_bits <= '0;
        end else if (tag_wr_en) begin
            valid_bits[tag_wr_index] <= tag_wr_entry.valid;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            look_valid <= 1'b0;
            valid_q    <= 1'b0;
        end else begin
            look_valid <= req_valid;
            valid_q    <= valid_bits[req_index];
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (req_valid) begin
            look_addr <= req_addr;
        end
    end

    // Tag RAM output lines up with look_addr one cycle after the request
    assign look_hit = valid_q && rd_entry.valid && (rd_entry.tag == look_tag);

endmodule

// ==== rtl/cpu_req_gen.sv ====
`include "cache_config.svh"

module cpu_req_gen
    import cache_pkg::*;
(
    input  logic  cpu_intf,
    input  logic  rst_n,
    input  logic  run,
    input  word_t seed,
    output logic  req_valid,
    output addr_t req_addr
);

    // x^32 + x^22 + x^2 + x + 1, Galois form shifting right
    localparam word_t LFSR_POLY = 32'h8020_0003;
    localparam int PER_W = $clog2(`REQ_PERIOD);
    localparam int HIST_W = $clog2(`HIST_DEPTH);

    logic [PER_W-1:0]  per_cnt;
    logic              fire;
    word_t             lfsr;
    word_t             lfsr_next;
    mem_index_t        hist [`HIST_DEPTH];
    logic [HIST_W-1:0] hist_wr_ptr;
    logic [HIST_W:0]   hist_count;
    logic [HIST_W:0]   pick;
    logic              reuse;
    mem_index_t        next_off;

    assign fire = run && (per_cnt == PER_W'(`REQ_PERIOD - 1));
    assign lfsr_next = (lfsr >> 1) ^ (lfsr[0] ? LFSR_POLY : '0);

    // Empty history forces a fresh address, so the first request is always fresh
    assign reuse = lfsr[8] && (hist_count != '0);
    assign pick = {1'b0, lfsr[11:9]} % hist_count;
    assign next_off = reuse ? hist[pick[HIST_W-1:0]] : lfsr[7:0];

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            per_cnt <= '0;
        end else if (!run || fire) begin
            per_cnt <= '0;
        end else begin
            per_cnt <= per_cnt + 1'b1;
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (!rst_n) begin
            req_valid   <= 1'b0;
            lfsr        <= seed;
            hist_wr_ptr <= '0;
            hist_count  <= '0;
        end else begin
            req_valid <= fire;
            if (fire) begin
                lfsr <= lfsr_next;
                if (!reuse) begin
                    hist_wr_ptr <= hist_wr_ptr + 1'b1;
                    // Ring wraps and overwrites the oldest once full
                    if (hist_count != (HIST_W + 1)'(`HIST_DEPTH)) begin
                        hist_count <= hist_count + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge cpu_intf) begin
        if (fire) begin
            req_addr <= `ADDR_BASE + addr_t'(next_off);
            if (!reuse) begin
                hist[hist_wr_ptr] <= next_off;
            end
        end
    end

endmodule

// ==== rtl/sync_ram.sv ====
module sync_ram #(
    parameter type entry_t = logic [31:0],
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                  cpu_intf,
    input  logic                  wr_en,
    input  logic [DEPTH_LOG2-1:0] wr_index,
    input  entry_t                wr_data,
    input  logic [DEPTH_LOG2-1:0] rd_index,
    output entry_t                rd_data
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    entry_t mem [DEPTH];

    // Read before write on a shared index
    always_ff @(posedge cpu_intf) begin
        if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
        rd_data <= mem[rd_index];
    end

endmodule

// ==== rtl/cache_pkg.sv ====
`include "cache_config.svh"

package cache_pkg;

    typedef logic [31:0] word_t;

    // Word address, no byte offset
    typedef logic [31:0] addr_t;

    typedef logic [`CACHE_LINES_LOG2-1:0] index_t;

    typedef logic [31-`CACHE_LINES_LOG2:0] tag_t;

    // Tag RAM entry
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // Offset from the address base into the backing store
    typedef logic [7:0] mem_index_t;

    typedef logic [15:0] count_t;

endpackage

// ==== include/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Cycles between two CPU read strobes
`define REQ_PERIOD 10

// Backing store wait on a miss
`define FILL_WAIT 4

// 16 lines, one word each
`define CACHE_LINES_LOG2 4

// Reuse history ring
`define HIST_DEPTH 8

// Start of the 256-word address window
`define ADDR_BASE 32'h0000_0a00

`endif
